// File: common/ncu_mon_pkg.sv
// Shared widths, link and report types, opcode encodings and the opcode decoder
package ncu_mon_pkg;

    // Link counts
    localparam int NUM_MCU   = 4;
    localparam int NUM_LINKS = 2 * NUM_MCU;

    // Transfer geometry of one nibble-serial link
    localparam int NIBBLE_W        = 4;
    localparam int NIBBLES_PER_PKT = 32;
    localparam int PKT_W           = NIBBLE_W * NIBBLES_PER_PKT;
    localparam int STALL_CNT_W     = 8;

    typedef logic [NIBBLE_W-1:0]                      nibble_t;
    typedef logic [PKT_W-1:0]                         packet_t;
    typedef logic [$clog2(NUM_LINKS)-1:0]             link_id_t;
    typedef logic [STALL_CNT_W-1:0]                   stall_cnt_t;
    typedef logic [$clog2(NIBBLES_PER_PKT+1)-1:0]     nib_cnt_t;

    // Downstream runs from the NCU to an MCU, upstream from an MCU to the NCU
    typedef enum logic
    {
        link_down,
        link_up
    } link_dir_t;

    // Command codes carried in the first nibble of a transfer
    typedef enum logic [NIBBLE_W-1:0]
    {
        op_read_nack  = 4'b0000,
        op_read_ack   = 4'b0001,
        op_ifill_ack  = 4'b0011,
        op_read_req   = 4'b0100,
        op_write_req  = 4'b0101,
        op_ifill_req  = 4'b0110,
        op_ifill_nack = 4'b0111,
        op_int        = 4'b1000,
        op_int_vec    = 4'b1100,
        op_unknown    = 4'b1111
    } mcu_opcode_t;

    // Sampled state of one link
    typedef struct packed
    {
        logic    vld;
        nibble_t data;
        logic    stall;
    } mcu_link_t;

    // One finished packet as it leaves the monitor
    typedef struct packed
    {
        link_id_t    link_id;
        mcu_opcode_t opcode;
        stall_cnt_t  stall_cycles;
        packet_t     packet;
    } mon_report_t;

    // A code that belongs to the other direction decodes as unknown
    function automatic mcu_opcode_t decode_opcode(input link_dir_t dir, input nibble_t nib);
        mcu_opcode_t op;
        op = op_unknown;
        if (dir == link_down)
        begin
            case (nib)
                4'b0100: op = op_read_req;
                4'b0101: op = op_write_req;
                4'b0110: op = op_ifill_req;
                default: op = op_unknown;
            endcase
        end
        else
        begin
            case (nib)
                4'b0000: op = op_read_nack;
                4'b0001: op = op_read_ack;
                4'b0011: op = op_ifill_ack;
                4'b0111: op = op_ifill_nack;
                4'b1000: op = op_int;
                4'b1100: op = op_int_vec;
                default: op = op_unknown;
            endcase
        end
        return op;
    endfunction

endpackage

// File: mcu_link/nibble_packet_assembler.sv
// Nibble accumulator with stall counter and completion pulse for one link
module nibble_packet_assembler
    import ncu_mon_pkg::*;
(
    input  logic       iol2clk,
    input  logic       rst_n,
    input  mcu_link_t  link,
    output logic       pkt_done,
    output packet_t    packet,
    output stall_cnt_t stall_cycles,
    output logic       first_nibble
);

    logic     accept;
    logic     active;
    logic     full;
    nib_cnt_t nib_cnt;

    // A nibble moves only when the receiver is not stalling
    assign accept = link.vld && !link.stall;
    assign full   = (nib_cnt == nib_cnt_t'(NIBBLES_PER_PKT));

    assign first_nibble = accept && (nib_cnt == '0);

    // Nibble count returns to zero whenever vld is sampled low
    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            nib_cnt <= '0;
        end
        else if (!link.vld)
        begin
            nib_cnt <= '0;
        end
        else if (accept && !full)
        begin
            nib_cnt <= nib_cnt + 1'b1;
        end
    end

    // Nibble n lands in bits [4n+3:4n]; anything past the last slot is dropped
    always_ff @(posedge iol2clk)
    begin
        if (accept && !full)
        begin
            packet[NIBBLE_W*nib_cnt[$clog2(NIBBLES_PER_PKT)-1:0] +: NIBBLE_W] <= link.data;
        end
    end

    // Tracks whether vld was high at the previous edge, so the start of a transfer is known
    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            active <= 1'b0;
        end
        else
        begin
            active <= link.vld;
        end
    end

    // The stall count restarts with a new transfer and holds after it ends
    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            stall_cycles <= '0;
        end
        else if (link.vld && !active)
        begin
            stall_cycles <= link.stall ? stall_cnt_t'(1) : '0;
        end
        else if (link.vld && link.stall && (stall_cycles != '1))
        begin
            stall_cycles <= stall_cycles + 1'b1;
        end
    end

    // Only a transfer closed with a full count completes
    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            pkt_done <= 1'b0;
        end
        else
        begin
            pkt_done <= !link.vld && full;
        end
    end

endmodule

// File: mcu_link/mcu_link_monitor.sv
// Single link monitor with opcode capture and a held report waiting for the arbiter
module mcu_link_monitor
    import ncu_mon_pkg::*;
#(
    parameter link_dir_t LINK_DIR = link_down
)
(
    input  logic        iol2clk,
    input  logic        rst_n,
    input  mcu_link_t   link,
    input  link_id_t    link_id,
    input  logic        grant,
    output logic        pending,
    output mon_report_t report
);

    logic        pkt_done;
    logic        first_nibble;
    packet_t     packet;
    stall_cnt_t  stall_cycles;
    mcu_opcode_t opcode_q;

    nibble_packet_assembler i_nibble_packet_assembler
    (
        .iol2clk      (iol2clk),
        .rst_n        (rst_n),
        .link         (link),
        .pkt_done     (pkt_done),
        .packet       (packet),
        .stall_cycles (stall_cycles),
        .first_nibble (first_nibble)
    );

    // The command comes from the first accepted nibble, decoded for this link's direction
    always_ff @(posedge iol2clk)
    begin
        if (first_nibble)
        begin
            opcode_q <= decode_opcode(LINK_DIR, link.data);
        end
    end

    // Snapshot the finished transfer, since a new one may begin before the grant arrives
    always_ff @(posedge iol2clk)
    begin
        if (pkt_done)
        begin
            report.link_id      <= link_id;
            report.opcode       <= opcode_q;
            report.stall_cycles <= stall_cycles;
            report.packet       <= packet;
        end
    end

    // A fresh completion takes precedence over a grant in the same cycle
    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            pending <= 1'b0;
        end
        else if (pkt_done)
        begin
            pending <= 1'b1;
        end
        else if (grant)
        begin
            pending <= 1'b0;
        end
    end

endmodule

// File: design/mon_report_arbiter.sv
// Fixed-priority arbiter merging the pending link reports into one registered stream
module mon_report_arbiter
    import ncu_mon_pkg::*;
(
    input  logic        iol2clk,
    input  logic        rst_n,
    input  logic        pending      [NUM_LINKS],
    input  mon_report_t link_reports [NUM_LINKS],
    output logic        grant        [NUM_LINKS],
    output mon_report_t report,
    output logic        report_valid
);

    logic     any_pending;
    link_id_t sel_idx;

    // Scan from the top down so the lowest pending index is left in sel_idx
    always_comb
    begin
        any_pending = 1'b0;
        sel_idx     = '0;
        for (int i = NUM_LINKS - 1; i >= 0; i--)
        begin
            if (pending[i])
            begin
                any_pending = 1'b1;
                sel_idx     = link_id_t'(i);
            end
        end
    end

    // One-hot grant back to the selected link monitor
    for (genvar g = 0; g < NUM_LINKS; g++)
    begin : g_grant
        assign grant[g] = any_pending && (sel_idx == link_id_t'(g));
    end

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            report_valid <= 1'b0;
        end
        else
        begin
            report_valid <= any_pending;
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (any_pending)
        begin
            report <= link_reports[sel_idx];
        end
    end

endmodule

// File: design/ncu_link_monitor.sv
// Top level of the NCU to MCU link monitor with eight link monitors and the report arbiter
module ncu_link_monitor
    import ncu_mon_pkg::*;
(
    input  logic        iol2clk,
    input  logic        rst_n,
    input  mcu_link_t   down_link [NUM_MCU],
    input  mcu_link_t   up_link   [NUM_MCU],
    output mon_report_t report,
    output logic        report_valid
);

    logic        pending      [NUM_LINKS];
    logic        grant        [NUM_LINKS];
    mon_report_t link_reports [NUM_LINKS];

    // Ids 0 to 3 are the downstream links, ids 4 to 7 the upstream ones
    for (genvar g = 0; g < NUM_MCU; g++)
    begin : g_mcu
        mcu_link_monitor
        #(
            .LINK_DIR (link_down)
        )
        i_down_monitor
        (
            .iol2clk (iol2clk),
            .rst_n   (rst_n),
            .link    (down_link[g]),
            .link_id (link_id_t'(g)),
            .grant   (grant[g]),
            .pending (pending[g]),
            .report  (link_reports[g])
        );

        mcu_link_monitor
        #(
            .LINK_DIR (link_up)
        )
        i_up_monitor
        (
            .iol2clk (iol2clk),
            .rst_n   (rst_n),
            .link    (up_link[g]),
            .link_id (link_id_t'(g + NUM_MCU)),
            .grant   (grant[g + NUM_MCU]),
            .pending (pending[g + NUM_MCU]),
            .report  (link_reports[g + NUM_MCU])
        );
    end

    mon_report_arbiter i_mon_report_arbiter
    (
        .iol2clk      (iol2clk),
        .rst_n        (rst_n),
        .pending      (pending),
        .link_reports (link_reports),
        .grant        (grant),
        .report       (report),
        .report_valid (report_valid)
    );

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock source and power-on reset sequencer
module tb_clock_gen
#(
    parameter int RESET_CYCLES = 5
)
(
    output logic iol2clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam realtime HALF_PERIOD = 10ns;

    initial
    begin
        iol2clk = 1'b0;
        forever #(HALF_PERIOD) iol2clk = ~iol2clk;
    end

    // Reset is released on a rising edge, like every other driven input
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge iol2clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verif/ncu_link_monitor_sva.sv
// Concurrent assertions on the link monitor top level for reset, opcode and report latency
module ncu_link_monitor_sva
    import ncu_mon_pkg::*;
(
    input logic        iol2clk,
    input logic        rst_n,
    input mcu_link_t   down_link [NUM_MCU],
    input mcu_link_t   up_link   [NUM_MCU],
    input mon_report_t report,
    input logic        report_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of property failures seen so far
    int fail_count = 0;

    // Command table keyed by direction bit and code, upstream when the id is 4 or above
    function automatic mcu_opcode_t expected_opcode(input link_id_t id, input nibble_t nib);
        logic [4:0] key;
        key = {(id >= link_id_t'(NUM_MCU)), nib};
        case (key)
            5'b0_0100: return op_read_req;
            5'b0_0101: return op_write_req;
            5'b0_0110: return op_ifill_req;
            5'b1_0000: return op_read_nack;
            5'b1_0001: return op_read_ack;
            5'b1_0011: return op_ifill_ack;
            5'b1_0111: return op_ifill_nack;
            5'b1_1000: return op_int;
            5'b1_1100: return op_int_vec;
            default:   return op_unknown;
        endcase
    endfunction

    a_reset_quiet: assert property (@(posedge iol2clk) !rst_n |=> !report_valid)
        else
        begin
            fail_count++;
            $error("report_valid rose while reset was held");
        end

    a_opcode_decode: assert property (@(posedge iol2clk) disable iff (!rst_n)
        report_valid |-> (report.opcode == expected_opcode(report.link_id, report.packet[3:0])))
        else
        begin
            fail_count++;
            $error("Opcode in report does not match the first nibble of link %0d",
                   report.link_id);
        end

    a_no_repeat: assert property (@(posedge iol2clk) disable iff (!rst_n)
        report_valid |=> !(report_valid && (report.link_id == $past(report.link_id))))
        else
        begin
            fail_count++;
            $error("Two back-to-back reports carry the same link id");
        end

    // Count accepted nibbles per link to know which vld falls close a full packet
    for (genvar g = 0; g < NUM_LINKS; g++)
    begin : g_link
        mcu_link_t link;
        int        accepted;
        logic      completes;

        if (g < NUM_MCU)
        begin : g_down
            assign link = down_link[g];
        end
        else
        begin : g_up
            assign link = up_link[g - NUM_MCU];
        end

        always @(posedge iol2clk)
        begin
            if (!rst_n || !link.vld)
            begin
                accepted <= 0;
            end
            else if (!link.stall && (accepted < NIBBLES_PER_PKT))
            begin
                accepted <= accepted + 1;
            end
        end

        assign completes = !link.vld && (accepted == NIBBLES_PER_PKT);

        a_report_follows: assert property (@(posedge iol2clk) disable iff (!rst_n)
            completes |-> ##[1:10] (report_valid && (report.link_id == link_id_t'(g))))
            else
            begin
                fail_count++;
                $error("Link %0d finished a packet but no report followed in 10 cycles", g);
            end
    end

endmodule

// File: verif/tb_ncu_link_monitor.sv
// Testbench top with random link stimulus, report scoreboard and run timeout
module tb_ncu_link_monitor
    import ncu_mon_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int XFERS_PER_LINK  = 40;
    localparam int MAX_STALLS      = 16;
    localparam int MAX_GAP         = 7;
    // Longest transfer is 35 accepted nibbles, 16 stalls and a 7 cycle gap
    localparam int MAX_XFER_CYCLES = 60;
    // Links run in parallel, so eight times the longest single-link run is a wide margin
    localparam int TIMEOUT_CYCLES  = 8 * (XFERS_PER_LINK * MAX_XFER_CYCLES + 100);
    // Report latency of up to 10 cycles plus time for the checker's last verdicts
    localparam int REPORT_WINDOW   = 14;

    typedef struct packed
    {
        link_id_t   link_id;
        stall_cnt_t stall_cycles;
        packet_t    packet;
    } expected_t;

    logic        iol2clk;
    logic        rst_n;
    mcu_link_t   links     [NUM_LINKS];
    mcu_link_t   down_link [NUM_MCU];
    mcu_link_t   up_link   [NUM_MCU];
    mon_report_t report;
    logic        report_valid;
    int          sva_fails;

    expected_t   exp_q [$];
    int          reports_expected = 0;
    int          reports_seen     = 0;
    int unsigned cycle_count      = 0;

    tb_clock_gen #(.RESET_CYCLES (5)) i_tb_clock_gen
    (
        .iol2clk (iol2clk),
        .rst_n   (rst_n)
    );

    for (genvar g = 0; g < NUM_MCU; g++)
    begin : g_wire
        assign down_link[g] = links[g];
        assign up_link[g]   = links[g + NUM_MCU];
    end

    ncu_link_monitor i_ncu_link_monitor
    (
        .iol2clk      (iol2clk),
        .rst_n        (rst_n),
        .down_link    (down_link),
        .up_link      (up_link),
        .report       (report),
        .report_valid (report_valid)
    );

    bind ncu_link_monitor ncu_link_monitor_sva i_ncu_link_monitor_sva
    (
        .iol2clk      (iol2clk),
        .rst_n        (rst_n),
        .down_link    (down_link),
        .up_link      (up_link),
        .report       (report),
        .report_valid (report_valid)
    );

    assign sva_fails = i_ncu_link_monitor.i_ncu_link_monitor_sva.fail_count;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // One vld-high transfer followed by a random gap, with its expected report if it completes
    task automatic send_transfer(input int k, input int n_accept, input nibble_t first);
        mcu_link_t cur;
        expected_t exp;
        int        taken;
        int        stalls;
        int        gap;
        taken            = 0;
        stalls           = 0;
        exp.link_id      = link_id_t'(k);
        exp.stall_cycles = '0;
        exp.packet       = '0;
        while (taken < n_accept)
        begin
            @(posedge iol2clk);
            cur.vld   = 1'b1;
            cur.stall = (stalls < MAX_STALLS) && (($urandom % 4) == 0);
            if (cur.stall)
            begin
                // Junk data while stalled must never land in the packet
                cur.data = nibble_t'($urandom);
                stalls++;
                if (exp.stall_cycles != '1)
                begin
                    exp.stall_cycles = exp.stall_cycles + 1'b1;
                end
            end
            else
            begin
                cur.data = (taken == 0) ? first : nibble_t'($urandom);
                if (taken < NIBBLES_PER_PKT)
                begin
                    exp.packet[NIBBLE_W*taken +: NIBBLE_W] = cur.data;
                end
                taken++;
            end
            links[k] <= cur;
        end
        gap = 1 + ($urandom % MAX_GAP);
        for (int i = 0; i < gap; i++)
        begin
            @(posedge iol2clk);
            cur.vld   = 1'b0;
            cur.stall = (($urandom % 2) == 1);
            cur.data  = nibble_t'($urandom);
            links[k] <= cur;
            if ((i == 0) && (taken >= NIBBLES_PER_PKT))
            begin
                exp_q.push_back(exp);
                reports_expected++;
            end
        end
    endtask

    // Mix of full, short and overlong transfers; first nibbles sweep all 16 codes
    task automatic run_link(input int k);
        int      n_accept;
        nibble_t first;
        for (int t = 0; t < XFERS_PER_LINK; t++)
        begin
            first = nibble_t'(t + k);
            if ((t % 5) == 3)
            begin
                n_accept = 1 + ($urandom % (NIBBLES_PER_PKT - 1));
            end
            else if ((t % 7) == 5)
            begin
                n_accept = NIBBLES_PER_PKT + 1 + ($urandom % 3);
            end
            else
            begin
                n_accept = NIBBLES_PER_PKT;
            end
            send_transfer(k, n_accept, first);
        end
    endtask

    // Per link the reports arrive in order, so the oldest entry for that link is the match
    task automatic check_report(input mon_report_t got);
        expected_t exp;
        int        idx;
        idx = -1;
        foreach (exp_q[i])
        begin
            if ((idx < 0) && (exp_q[i].link_id == got.link_id))
            begin
                idx = i;
            end
        end
        assert (idx >= 0)
        else
        begin
            fail_run($sformatf("Unexpected report from link %0d", got.link_id));
        end
        if (idx >= 0)
        begin
            exp = exp_q[idx];
            exp_q.delete(idx);
            reports_seen++;
            assert ((got.packet == exp.packet) && (got.stall_cycles == exp.stall_cycles))
            else
            begin
                if (got.packet != exp.packet)
                begin
                    fail_run($sformatf("FAIL packet_link%0d expected %h actual %h",
                                       got.link_id, exp.packet, got.packet));
                end
                else
                begin
                    fail_run($sformatf("FAIL stall_cycles_link%0d expected %0d actual %0d",
                                       got.link_id, exp.stall_cycles, got.stall_cycles));
                end
            end
        end
    endtask

    always @(posedge iol2clk)
    begin
        if (rst_n && report_valid)
        begin
            check_report(report);
        end
    end

    // Watch the bound checker for a failed property
    always @(posedge iol2clk)
    begin
        if (sva_fails != 0)
        begin
            fail_run("A property of the bound checker on the DUT failed");
        end
    end

    always @(posedge iol2clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            fail_run($sformatf("Run hung: not finished after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial
    begin
        void'($urandom(32'hc996));
        for (int i = 0; i < NUM_LINKS; i++)
        begin
            links[i] = '0;
        end
        wait (rst_n);
        fork
            run_link(0);
            run_link(1);
            run_link(2);
            run_link(3);
            run_link(4);
            run_link(5);
            run_link(6);
            run_link(7);
        join
        // Leave room for the last reports and any stray one before deciding
        repeat (REPORT_WINDOW) @(posedge iol2clk);
        if ((exp_q.size() == 0) && (sva_fails == 0))
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            fail_run($sformatf("Run ended with %0d of %0d reports received and %0d property failures",
                               reports_seen, reports_expected, sva_fails));
        end
    end

endmodule

// File: tb.f
common/ncu_mon_pkg.sv
mcu_link/nibble_packet_assembler.sv
mcu_link/mcu_link_monitor.sv
design/mon_report_arbiter.sv
design/ncu_link_monitor.sv
verif/tb_clock_gen.sv
verif/ncu_link_monitor_sva.sv
verif/tb_ncu_link_monitor.sv
